/* Makefile */
# Verilator build and run of the EEPROM host controller testbench

VERILATOR ?= verilator
TOP       ?= tb_eeprom_host
FILELIST  ?= eeprom_host.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_TEXT ?= No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* design/eeprom_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

`include "eeprom_defs.svh"

module eeprom_ctrl (
    input  wire                       CLK,
    input  wire                       RESET,
    input  wire                       wr,
    input  wire                       rd,
    input  wire eeprom_pkg::ee_addr_t addr,
    input  wire eeprom_pkg::ee_byte_t wr_data,
    input  wire                       cmd_done,
    input  wire eeprom_pkg::ee_byte_t rx_byte,
    input  wire                       slave_nack,
    output logic                      busy,
    output logic                      done,
    output logic                      nack,
    output eeprom_pkg::ee_byte_t      rd_data,
    output logic                      cmd_valid,
    output eeprom_pkg::bit_cmd_e      cmd,
    output eeprom_pkg::ee_byte_t      tx_byte,
    output logic                      master_ack
);

    import eeprom_pkg::*;

    ctrl_state_e state;
    ctrl_state_e next_state;
    ee_addr_t    addr_r;
    ee_byte_t    data_r;
    logic        rd_op;
    logic        accept;

    assign accept     = (state == IDLE) && (wr || rd);
    assign busy       = (state != IDLE);
    assign done       = (state == DONE);
    assign master_ack = 1'b1; // single-byte reads end with not-acknowledge

    // command that goes out with the cmd_valid pulse
    always_comb
    begin
        case (state)
            START, RESTART: cmd = BC_START;
            DATA_R:         cmd = BC_READ;
            STOP:           cmd = BC_STOP;
            default:        cmd = BC_WRITE;
        endcase
    end

    always_comb
    begin
        case (state)
            CTRL_W:  tx_byte = {`EE_DEV_CODE, addr_r[`EE_ADDR_W-1:8], 1'b0};
            ADDR:    tx_byte = addr_r[7:0];
            DATA_W:  tx_byte = data_r;
            CTRL_R:  tx_byte = {`EE_DEV_CODE, addr_r[`EE_ADDR_W-1:8], 1'b1};
            default: tx_byte = 8'h00;
        endcase
    end

    // missing acknowledge on any written byte goes straight to stop
    always_comb
    begin
        case (state)
            START:   next_state = CTRL_W;
            CTRL_W:  next_state = slave_nack ? STOP : ADDR;
            ADDR:
            begin
                if (slave_nack)
                    next_state = STOP;
                else
                    next_state = rd_op ? RESTART : DATA_W;
            end
            DATA_W:  next_state = STOP;
            RESTART: next_state = CTRL_R;
            CTRL_R:  next_state = slave_nack ? STOP : DATA_R;
            DATA_R:  next_state = STOP;
            STOP:    next_state = DONE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= IDLE;
            cmd_valid <= 1'b0;
            nack      <= 1'b0;
        end
        else
        begin
            cmd_valid <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (accept)
                    begin
                        state     <= START;
                        cmd_valid <= 1'b1;
                        nack      <= 1'b0;
                    end
                end
                DONE: state <= IDLE;
                default:
                begin
                    if (cmd_done)
                    begin
                        state     <= next_state;
                        cmd_valid <= (next_state != DONE);
                        if (cmd == BC_WRITE && slave_nack)
                            nack <= 1'b1;
                    end
                end
            endcase
        end
    end

    // request registers
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            addr_r <= addr;
            data_r <= wr_data;
            rd_op  <= !wr; // write wins on a tie
        end
        if (state == DATA_R && cmd_done)
            rd_data <= rx_byte;
    end

    // strobes while busy leave the request untouched
    a_accept_idle: assert property (@(posedge CLK) disable iff (RESET)
        (wr || rd) && busy |=> $stable(addr_r) && $stable(data_r) && $stable(rd_op));

    a_no_cmd_idle: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> !(state inside {IDLE, DONE}));

endmodule

`default_nettype wire

/* design/eeprom_defs.svh */
`ifndef EEPROM_DEFS_SVH
`define EEPROM_DEFS_SVH

// 2 KB part, upper three address bits ride in the control byte
`define EE_ADDR_W 11

`define EE_DEV_CODE 4'b1010 // fixed control byte nibble

// CLK cycles per quarter of an SCL period
`define EE_QUARTER 4

`endif

/* design/eeprom_host_top.sv */
`default_nettype none
`timescale 1ns/1ps

module eeprom_host_top (
    input  wire                       CLK,
    input  wire                       RESET,
    input  wire                       wr,
    input  wire                       rd,
    input  wire eeprom_pkg::ee_addr_t addr,
    input  wire eeprom_pkg::ee_byte_t wr_data,
    output logic                      busy,
    output logic                      done,
    output logic                      nack,
    output eeprom_pkg::ee_byte_t      rd_data,
    output logic                      SCL,
    inout  wire                       SDA
);

    import eeprom_pkg::*;

    logic     cmd_valid;
    bit_cmd_e cmd;
    ee_byte_t tx_byte;
    logic     master_ack;
    logic     cmd_done;
    ee_byte_t rx_byte;
    logic     slave_nack;
    logic     sda_oe;
    wire      sda_in;

    // open drain, pull-up sits outside
    assign SDA    = sda_oe ? 1'b0 : 1'bz;
    assign sda_in = SDA;

    eeprom_ctrl u_ctrl (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .wr_data    (wr_data),
        .cmd_done   (cmd_done),
        .rx_byte    (rx_byte),
        .slave_nack (slave_nack),
        .busy       (busy),
        .done       (done),
        .nack       (nack),
        .rd_data    (rd_data),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .tx_byte    (tx_byte),
        .master_ack (master_ack)
    );

    i2c_bit_engine u_bit (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .tx_byte    (tx_byte),
        .master_ack (master_ack),
        .sda_in     (sda_in),
        .cmd_done   (cmd_done),
        .rx_byte    (rx_byte),
        .slave_nack (slave_nack),
        .sda_oe     (sda_oe),
        .SCL        (SCL)
    );

endmodule

`default_nettype wire

/* design/eeprom_pkg.sv */
`default_nettype none

`include "eeprom_defs.svh"

package eeprom_pkg;

    typedef logic [`EE_ADDR_W-1:0] ee_addr_t; // word address
    typedef logic [7:0]            ee_byte_t; // data, address low or control byte

    // single bus operations of the bit engine
    typedef enum logic [1:0] {
        BC_START,
        BC_STOP,
        BC_WRITE,
        BC_READ
    } bit_cmd_e;

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_W,
        ADDR,
        DATA_W,
        RESTART, // repeated start before the read control byte
        CTRL_R,
        DATA_R,
        STOP,
        DONE
    } ctrl_state_e;

    typedef enum logic [2:0] {
        B_IDLE,
        B_START,
        B_BITS,
        B_ACK, // ninth clock of a byte
        B_STOP
    } bit_state_e;

endpackage

`default_nettype wire

/* design/i2c_bit_engine.sv */
`default_nettype none
`timescale 1ns/1ps

`include "eeprom_defs.svh"

module i2c_bit_engine #(
    parameter int QUARTER = `EE_QUARTER
) (
    input  wire                   CLK,
    input  wire                   RESET,
    input  wire                   cmd_valid,
    input  wire eeprom_pkg::bit_cmd_e cmd,
    input  wire eeprom_pkg::ee_byte_t tx_byte,
    input  wire                   master_ack,
    input  wire                   sda_in,
    output logic                  cmd_done,
    output eeprom_pkg::ee_byte_t  rx_byte,
    output logic                  slave_nack,
    output logic                  sda_oe,
    output logic                  SCL
);

    import eeprom_pkg::*;

    localparam int QW = (QUARTER > 1) ? $clog2(QUARTER) : 1;

    bit_state_e  state;
    logic [QW-1:0] qcnt;
    logic [1:0]  phase;   // quarter within the current bit slot
    logic [2:0]  bitcnt;
    logic        tick;
    logic        first_oe;
    ee_byte_t    shreg;
    logic        rd_mode;
    logic        mack_r;

    assign tick    = (qcnt == QW'(QUARTER - 1));
    assign rx_byte = shreg;

    // SDA level set in the second quarter, while SCL is still low
    always_comb
    begin
        case (state)
            B_START: first_oe = 1'b0;
            B_STOP:  first_oe = 1'b1;
            B_BITS:  first_oe = !rd_mode && !shreg[7];
            B_ACK:   first_oe = rd_mode && !mack_r;
            default: first_oe = sda_oe;
        endcase
    end

    // every slot: SDA set, SCL up, mid-high action, SCL down
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state      <= B_IDLE;
            qcnt       <= '0;
            phase      <= 2'd0;
            bitcnt     <= 3'd0;
            SCL        <= 1'b1;
            sda_oe     <= 1'b0;
            cmd_done   <= 1'b0;
            slave_nack <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            if (state == B_IDLE)
            begin
                qcnt   <= '0;
                phase  <= 2'd0;
                bitcnt <= 3'd0;
                if (cmd_valid)
                begin
                    case (cmd)
                        BC_START: state <= B_START;
                        BC_STOP:  state <= B_STOP;
                        default:  state <= B_BITS;
                    endcase
                end
            end
            else
            begin
                qcnt <= tick ? '0 : qcnt + 1'b1;
                if (tick)
                begin
                    phase <= phase + 2'd1;
                    case (phase)
                        2'd0: sda_oe <= first_oe;
                        2'd1: SCL <= 1'b1;
                        2'd2:
                        begin
                            if (state == B_START)
                                sda_oe <= 1'b1; // SDA falls under high SCL
                            else if (state == B_STOP)
                                sda_oe <= 1'b0; // SDA rises under high SCL
                            else if (state == B_ACK && !rd_mode)
                                slave_nack <= sda_in;
                        end
                        default:
                        begin
                            if (state != B_STOP)
                                SCL <= 1'b0; // bus stays high only after stop
                            if (state == B_BITS && bitcnt != 3'd7)
                                bitcnt <= bitcnt + 3'd1;
                            else if (state == B_BITS)
                                state <= B_ACK;
                            else
                            begin
                                state    <= B_IDLE;
                                cmd_done <= 1'b1;
                            end
                        end
                    endcase
                end
            end
        end
    end

    // shift register serves both directions
    always_ff @(posedge CLK)
    begin
        if (state == B_IDLE && cmd_valid)
        begin
            shreg   <= tx_byte;
            rd_mode <= (cmd == BC_READ);
            mack_r  <= master_ack;
        end
        else if (state == B_BITS && tick)
        begin
            if (rd_mode && phase == 2'd2)
                shreg <= {shreg[6:0], sda_in}; // mid-high sample
            else if (!rd_mode && phase == 2'd3)
                shreg <= {shreg[6:0], 1'b0};
        end
    end

    // sequencer waits for cmd_done before the next command
    a_cmd_in_idle: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> state == B_IDLE);

    a_done_pulse: assert property (@(posedge CLK) disable iff (RESET)
        cmd_done |=> !cmd_done);

endmodule

`default_nettype wire

/* eeprom_host.f */
+incdir+design
design/eeprom_pkg.sv
design/i2c_bit_engine.sv
design/eeprom_ctrl.sv
design/eeprom_host_top.sv
tb/eeprom_model.sv
tb/tb_eeprom_host.sv

/* tb/eeprom_model.sv */
`default_nettype none
`timescale 1ns/1ps

`include "eeprom_defs.svh"

module eeprom_model (
    input  wire busy,
    input  wire SCL,
    inout  wire SDA
);

    localparam int EV_BYTE  = 0;
    localparam int EV_START = 1;
    localparam int EV_STOP  = 2;

    logic [7:0]            mem [0:(1 << `EE_ADDR_W)-1];
    logic                  sda_drv;
    logic [2:0]            block;
    logic [7:0]            word_ptr;
    logic [`EE_ADDR_W-1:0] wr_addr;
    logic [7:0]            wr_buf;
    logic                  wr_pend;

    assign SDA = sda_drv ? 1'b0 : 1'bz;

    // eight bits MSB first, cut short by a start or stop under high SCL
    task automatic get_byte(output logic [7:0] val, output int ev);
        logic b;
        int   i;
        val = 8'h00;
        ev  = EV_BYTE;
        for (i = 0; i < 8; i++)
        begin
            @(posedge SCL);
            b = SDA;
            while (SCL === 1'b1 && SDA === b)
                @(SCL or SDA);
            if (SCL === 1'b1)
            begin
                ev = (SDA === 1'b0) ? EV_START : EV_STOP;
                return;
            end
            val = {val[6:0], b};
        end
    endtask

    task automatic send_ack();
        sda_drv = 1'b1;
        @(posedge SCL);
        @(negedge SCL);
        sda_drv = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] val);
        int i;
        for (i = 7; i >= 0; i--)
        begin
            sda_drv = !val[i];
            @(posedge SCL);
            @(negedge SCL);
        end
        sda_drv = 1'b0;
        @(posedge SCL); // master ack slot, not checked
        @(negedge SCL);
    endtask

    // one segment from a start up to the next start or stop
    task automatic serve_segment(output int ev);
        logic [7:0] val;
        logic       acked;
        int         n;
        get_byte(val, ev);
        acked = (ev == EV_BYTE) && !busy && (val[7:4] == `EE_DEV_CODE);
        if (acked)
        begin
            send_ack();
            block = val[3:1];
            if (val[0])
            begin
                send_byte(mem[{block, word_ptr}]);
                word_ptr = word_ptr + 8'd1;
                acked    = 1'b0; // single byte, then stop
            end
        end
        n = 0;
        while (ev == EV_BYTE)
        begin
            get_byte(val, ev);
            acked = acked && (ev == EV_BYTE) && !busy;
            if (acked)
            begin
                send_ack();
                if (n == 0)
                    word_ptr = val;
                else
                begin
                    wr_addr  = {block, word_ptr};
                    wr_buf   = val;
                    wr_pend  = 1'b1;
                    word_ptr = word_ptr + 8'd1;
                end
                n++;
            end
        end
    endtask

    initial
    begin
        int i;
        int ev;
        sda_drv  = 1'b0;
        word_ptr = 8'h00;
        block    = 3'd0;
        wr_pend  = 1'b0;
        for (i = 0; i < (1 << `EE_ADDR_W); i++)
            mem[i] = 8'(i ^ (i >> 3) ^ (i >> 8)); // every address bit counts
        forever
        begin
            @(negedge SDA);
            if (SCL === 1'b1)
            begin
                ev = EV_START;
                while (ev == EV_START)
                    serve_segment(ev);
                if (wr_pend)
                    mem[wr_addr] = wr_buf; // write cycle starts at stop
                wr_pend = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_eeprom_host.sv */
`default_nettype none
`timescale 1ns/1ps

`include "eeprom_defs.svh"

module tb_eeprom_host;

    import eeprom_pkg::*;

    localparam int SCL_CYC   = `EE_QUARTER * 4;
    localparam int TRANS_CYC = 40 * SCL_CYC + 20; // longest transaction plus command gaps
    localparam int N_TRANS   = 46;
    localparam int N_RAND    = 20;

    logic     CLK;
    logic     RESET;
    logic     wr;
    logic     rd;
    ee_addr_t addr;
    ee_byte_t wr_data;
    logic     busy;
    logic     done;
    logic     nack;
    ee_byte_t rd_data;
    logic     SCL;
    wire      SDA;
    logic     ee_busy;

    ee_byte_t    exp_mem [0:(1 << `EE_ADDR_W)-1];
    logic [31:0] rng_state;
    ee_addr_t    known_addr;
    int          done_cnt;
    int          accept_cnt;

    pullup (SDA);

    eeprom_host_top DUT (.*);

    eeprom_model u_model (.busy(ee_busy), .SCL(SCL), .SDA(SDA));

    initial
    begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        if (RESET)
            done_cnt <= 0;
        else if (done)
            done_cnt <= done_cnt + 1;
    end

    // whole run plus margin for reset and idle cycles
    initial
    begin
        repeat (N_TRANS * TRANS_CYC + 500) @(posedge CLK);
        fail_run("watchdog expired before the tests finished");
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_byte(input string name, input ee_addr_t a, input ee_byte_t got,
                              input ee_byte_t exp);
        if (got !== exp)
            fail_run($sformatf("ERROR %s at addr 0x%03h: got 0x%02h, expected 0x%02h",
                               name, a, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            fail_run($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic step();
        @(posedge CLK);
        #1;
    endtask

    task automatic issue(input logic w, input logic r, input ee_addr_t a, input ee_byte_t d);
        wr      = w;
        rd      = r;
        addr    = a;
        wr_data = d;
        step();
        wr = 1'b0;
        rd = 1'b0;
        accept_cnt++;
        check_flag("busy", busy, 1'b1);
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (done !== 1'b1)
        begin
            if (n == 2 * TRANS_CYC)
                fail_run("no done pulse within the transaction time");
            step();
            n++;
        end
        check_flag("SCL", SCL, 1'b1); // bus idle again at done
        check_flag("SDA", SDA, 1'b1);
    endtask

    task automatic close_transaction();
        step();
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_count("done pulses", done_cnt, accept_cnt);
    endtask

    task automatic do_write(input ee_addr_t a, input ee_byte_t d, input logic exp_nack);
        issue(1'b1, 1'b0, a, d);
        wait_done();
        check_flag("nack", nack, exp_nack);
        if (!exp_nack)
            exp_mem[a] = d;
        close_transaction();
    endtask

    task automatic do_read(input ee_addr_t a, input logic exp_nack);
        issue(1'b0, 1'b1, a, 8'h00);
        wait_done();
        check_flag("nack", nack, exp_nack);
        if (!exp_nack)
            check_byte("rd_data", a, rd_data, exp_mem[a]);
        close_transaction();
    endtask

    task automatic reset_idle_state();
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("nack", nack, 1'b0);
        check_flag("SCL", SCL, 1'b1);
        check_flag("SDA", SDA, 1'b1);
        repeat (4) step();
        check_count("done pulses", done_cnt, 0); // no done without a request
    endtask

    task automatic write_then_read();
        logic [31:0] r;
        r          = next_rand();
        known_addr = ee_addr_t'(r[26:16]);
        do_write(known_addr, r[7:0], 1'b0);
        do_read(known_addr, 1'b0);
    endtask

    // upper address bits step through all eight blocks
    task automatic random_fill();
        ee_addr_t    a_list [N_RAND];
        logic [31:0] r;
        int          i;
        for (i = 0; i < N_RAND; i++)
        begin
            r         = next_rand();
            a_list[i] = {3'(i % 8), r[7:0]};
            do_write(a_list[i], r[15:8], 1'b0);
        end
        for (i = 0; i < N_RAND; i++)
            do_read(a_list[i], 1'b0);
    endtask

    task automatic busy_slave_write();
        ee_busy = 1'b1;
        do_write(known_addr, ~exp_mem[known_addr], 1'b1);
        ee_busy = 1'b0;
        do_read(known_addr, 1'b0);
    endtask

    task automatic tie_and_ignored_strobes();
        logic [31:0] r;
        ee_addr_t    a;
        int          i;
        r = next_rand();
        a = {r[18:16], r[7:0]};
        issue(1'b1, 1'b1, a, r[15:8]);
        rd   = 1'b1; // lands while busy
        addr = ~a;
        step();
        rd = 1'b0;
        wait_done();
        check_flag("nack", nack, 1'b0);
        exp_mem[a] = r[15:8];
        close_transaction();
        for (i = 0; i < 4; i++)
        begin
            step();
            check_flag("busy", busy, 1'b0);
        end
        check_count("done pulses", done_cnt, accept_cnt);
        do_read(a, 1'b0);
    endtask

    initial
    begin
        rng_state  = 32'd37;
        RESET      = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = '0;
        wr_data    = '0;
        ee_busy    = 1'b0;
        accept_cnt = 0;
        repeat (2) @(posedge CLK);
        #1;
        RESET = 1'b0;
        reset_idle_state();
        write_then_read();
        random_fill();
        busy_slave_write();
        tie_and_ignored_strobes();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
